// File: logic/bpu_pkg.sv
package bpu_pkg;

    // datapath
    localparam int xlen = 32;
    localparam int hist_width = 16;

    // pattern history table, indexed by pc[9:1] ^ history[8:0]
    localparam int pht_entries = 512;
    localparam int pht_index_width = 9;
    localparam int pht_index_lsb = 1;

    // branch target buffer, index pc[9:2], tag from the top pc bits
    localparam int btb_entries = 256;
    localparam int btb_index_width = 8;
    localparam int btb_index_lsb = 2;
    localparam int btb_tag_width = 14;

    // return stack, pointer counts 0..ras_depth
    localparam int ras_depth = 32;
    localparam int ras_ptr_width = 6;

    // link register x1
    localparam logic [4:0] ret_reg = 5'd1;

    typedef enum logic [6:0] {
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111
    } opcode_t;

    typedef enum logic [2:0] {
        kind_none,
        kind_branch,
        kind_jal,
        kind_jalr_plain,
        kind_call_jal,
        kind_call_jalr,
        kind_ret
    } branch_kind_t;

    typedef logic [1:0] ctr_t;

    localparam ctr_t ctr_weak_nt = 2'b01;

endpackage

// File: logic/resolve_if.sv
`timescale 1ns/1ps

interface resolve_if
    import bpu_pkg::*;
();

    logic                  commit;
    logic                  restore;
    logic                  taken;
    branch_kind_t          kind;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       target;
    logic [hist_width-1:0] history;

    modport source (
        output commit, restore, taken, kind, pc, target, history
    );

    modport sink (
        input commit, restore, taken, kind, pc, target, history
    );

endinterface

// File: logic/inst_decode.sv
`timescale 1ns/1ps

module inst_decode
    import bpu_pkg::*;
(
    input  logic [xlen-1:0] inst_i,
    output branch_kind_t    kind_o,
    output logic [xlen-1:0] branch_offset_o,
    output logic [xlen-1:0] jal_offset_o
);

    logic [4:0] rd;
    logic [4:0] rs1;

    assign rd  = inst_i[11:7];
    assign rs1 = inst_i[19:15];

    always_comb begin
        kind_o = kind_none;
        case (inst_i[6:0])
            op_branch: kind_o = kind_branch;
            // jal writing a link register is a call
            op_jal:    kind_o = (rd != 5'd0) ? kind_call_jal : kind_jal;
            op_jalr: begin
                if (rd == 5'd0 && rs1 == ret_reg) begin
                    kind_o = kind_ret;
                end else if (rd != 5'd0) begin
                    kind_o = kind_call_jalr;
                end else begin
                    kind_o = kind_jalr_plain;
                end
            end
            default:   kind_o = kind_none;
        endcase
    end

    // b-type and j-type immediates
    assign branch_offset_o = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign jal_offset_o = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

endmodule

// File: logic/resolve_stage.sv
`timescale 1ns/1ps

module resolve_stage
    import bpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  flush_i,
    input  logic                  if_stall_i,
    input  logic                  ex_branch_valid_i,
    input  logic                  ex_branch_taken_i,
    input  logic [xlen-1:0]       ex_pc_i,
    input  logic [hist_width-1:0] ex_history_i,
    input  logic [xlen-1:0]       ex_target_i,
    input  logic [xlen-1:0]       ex_inst_i,
    resolve_if.source             res
);

    branch_kind_t ex_kind;

    inst_decode u_ex_decode (
        .inst_i          (ex_inst_i),
        .kind_o          (ex_kind),
        .branch_offset_o (),
        .jal_offset_o    ()
    );

    // tables only ever see these two strobes
    assign res.commit  = ex_branch_valid_i && !if_stall_i && !flush_i;
    assign res.restore = flush_i;
    assign res.taken   = ex_branch_taken_i;
    assign res.kind    = ex_kind;
    assign res.pc      = ex_pc_i;
    assign res.target  = ex_target_i;
    assign res.history = ex_history_i;

    // a commit needs a fully known resolution
    a_commit_known : assert property (
        @(posedge clk) res.commit
            |-> !$isunknown({ex_inst_i, ex_pc_i, ex_target_i, ex_branch_taken_i})
    );

endmodule

// File: logic/btb.sv
`timescale 1ns/1ps

module btb
    import bpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [xlen-1:0] lookup_pc_i,
    resolve_if.sink         res,
    output logic            hit_o,
    output logic [xlen-1:0] target_o
);

    logic [btb_tag_width-1:0] tag_q [btb_entries];
    logic [xlen-1:0]          target_q [btb_entries];
    logic [btb_entries-1:0]   valid_q;

    logic [btb_index_width-1:0] lookup_idx;
    logic [btb_tag_width-1:0]   lookup_tag;
    logic [btb_index_width-1:0] upd_idx;
    logic [btb_tag_width-1:0]   upd_tag;
    logic                       upd_en;

    assign lookup_idx = lookup_pc_i[btb_index_lsb +: btb_index_width];
    assign lookup_tag = lookup_pc_i[xlen-1 -: btb_tag_width];
    assign upd_idx    = res.pc[btb_index_lsb +: btb_index_width];
    assign upd_tag    = res.pc[xlen-1 -: btb_tag_width];

    // any taken control transfer allocates
    assign upd_en = res.commit && res.taken && (res.kind != kind_none);

    assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign target_o = target_q[lookup_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (upd_en) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_en) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= res.target;
        end
    end

endmodule

// File: logic/direction_predictor.sv
`timescale 1ns/1ps

module direction_predictor
    import bpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [xlen-1:0]       lookup_pc_i,
    resolve_if.sink               res,
    output logic                  taken_o,
    output logic [hist_width-1:0] history_o
);

    ctr_t pht_q [pht_entries];

    logic [hist_width-1:0]      history_q;
    logic [pht_index_width-1:0] lookup_idx;
    logic [pht_index_width-1:0] upd_idx;
    ctr_t                       upd_ctr;
    logic                       upd_en;

    // gshare style hashing
    assign lookup_idx = lookup_pc_i[pht_index_lsb +: pht_index_width]
                      ^ history_q[pht_index_width-1:0];
    assign upd_idx    = res.pc[pht_index_lsb +: pht_index_width]
                      ^ res.history[pht_index_width-1:0];

    assign upd_en  = res.commit && (res.kind == kind_branch);
    assign upd_ctr = pht_q[upd_idx];

    assign taken_o   = pht_q[lookup_idx][1];
    assign history_o = history_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            history_q <= '0;
        end else if (res.restore) begin
            history_q <= res.history;
        end else if (upd_en) begin
            history_q <= {history_q[hist_width-2:0], res.taken};
        end
    end

    // saturating step on every resolved branch
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < pht_entries; i++) begin
                pht_q[i] <= ctr_weak_nt;
            end
        end else if (upd_en) begin
            if (res.taken && upd_ctr != 2'b11) begin
                pht_q[upd_idx] <= upd_ctr + 2'd1;
            end else if (!res.taken && upd_ctr != 2'b00) begin
                pht_q[upd_idx] <= upd_ctr - 2'd1;
            end
        end
    end

endmodule

// File: logic/return_stack.sv
`timescale 1ns/1ps

module return_stack
    import bpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    resolve_if.sink         res,
    output logic            top_valid_o,
    output logic [xlen-1:0] top_addr_o
);

    logic [xlen-1:0] stack_q [ras_depth];

    logic [ras_ptr_width-1:0] ptr_q;
    logic [ras_ptr_width-1:0] top_ptr;
    logic                     push;
    logic                     pop;
    logic                     full;
    logic [xlen-1:0]          link_addr;

    assign push      = res.commit && (res.kind inside {kind_call_jal, kind_call_jalr});
    assign pop       = res.commit && (res.kind == kind_ret);
    assign full      = (ptr_q >= ras_depth);
    assign link_addr = res.pc + 32'd4;

    assign top_ptr     = ptr_q - 1'b1;
    assign top_valid_o = (ptr_q != '0);
    assign top_addr_o  = stack_q[top_ptr[ras_ptr_width-2:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr_q <= '0;
        end else if (push) begin
            // overflow wraps to the bottom entry
            ptr_q <= full ? ras_ptr_width'(1) : ptr_q + 1'b1;
        end else if (pop && top_valid_o) begin
            ptr_q <= top_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            if (full) begin
                stack_q[0] <= link_addr;
            end else begin
                stack_q[ptr_q[ras_ptr_width-2:0]] <= link_addr;
            end
        end
    end

    a_ptr_in_range : assert property (
        @(posedge clk) disable iff (rst) ptr_q <= ras_depth
    );

endmodule

// File: logic/next_pc_select.sv
`timescale 1ns/1ps

module next_pc_select
    import bpu_pkg::*;
(
    input  logic            flush_i,
    input  logic [xlen-1:0] if_pc_i,
    input  branch_kind_t    kind_i,
    input  logic [xlen-1:0] branch_offset_i,
    input  logic [xlen-1:0] jal_offset_i,
    input  logic            btb_hit_i,
    input  logic [xlen-1:0] btb_target_i,
    input  logic            dir_taken_i,
    input  logic            ras_valid_i,
    input  logic [xlen-1:0] ras_addr_i,
    output logic            branch_or_not_o,
    output logic [xlen-1:0] pdt_pc_o,
    output logic            pdt_res_o
);

    logic [xlen-1:0] seq_pc;

    assign seq_pc          = if_pc_i + 32'd4;
    assign branch_or_not_o = (kind_i != kind_none) && !flush_i;

    always_comb begin
        pdt_res_o = 1'b0;
        pdt_pc_o  = seq_pc;
        if (!flush_i) begin
            case (kind_i)
                kind_ret: begin
                    // stack first, btb as fallback
                    if (ras_valid_i) begin
                        pdt_res_o = 1'b1;
                        pdt_pc_o  = ras_addr_i;
                    end else if (btb_hit_i) begin
                        pdt_res_o = 1'b1;
                        pdt_pc_o  = btb_target_i;
                    end
                end
                kind_jalr_plain, kind_call_jalr: begin
                    if (btb_hit_i) begin
                        pdt_res_o = 1'b1;
                        pdt_pc_o  = btb_target_i;
                    end
                end
                kind_jal, kind_call_jal: begin
                    pdt_res_o = 1'b1;
                    pdt_pc_o  = if_pc_i + jal_offset_i;
                end
                kind_branch: begin
                    if (dir_taken_i) begin
                        pdt_res_o = 1'b1;
                        pdt_pc_o  = btb_hit_i ? btb_target_i : if_pc_i + branch_offset_i;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// File: logic/bpu_top.sv
`timescale 1ns/1ps

module bpu_top
    import bpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  if_stall_i,
    input  logic                  flush_i,
    input  logic [xlen-1:0]       if_pc_i,
    input  logic [xlen-1:0]       if_inst_i,
    input  logic                  ex_branch_valid_i,
    input  logic                  ex_branch_taken_i,
    input  logic [xlen-1:0]       ex_pc_i,
    input  logic [hist_width-1:0] ex_history_i,
    input  logic [xlen-1:0]       ex_target_i,
    input  logic [xlen-1:0]       ex_inst_i,
    output logic                  branch_or_not_o,
    output logic [xlen-1:0]       pdt_pc_o,
    output logic                  pdt_res_o,
    output logic [hist_width-1:0] history_o
);

    branch_kind_t    if_kind;
    logic [xlen-1:0] if_branch_offset;
    logic [xlen-1:0] if_jal_offset;
    logic            btb_hit;
    logic [xlen-1:0] btb_target;
    logic            dir_taken;
    logic            ras_valid;
    logic [xlen-1:0] ras_addr;

    resolve_if res_bus ();

    inst_decode u_if_decode (
        .inst_i          (if_inst_i),
        .kind_o          (if_kind),
        .branch_offset_o (if_branch_offset),
        .jal_offset_o    (if_jal_offset)
    );

    resolve_stage u_resolve_stage (
        .clk               (clk),
        .flush_i           (flush_i),
        .if_stall_i        (if_stall_i),
        .ex_branch_valid_i (ex_branch_valid_i),
        .ex_branch_taken_i (ex_branch_taken_i),
        .ex_pc_i           (ex_pc_i),
        .ex_history_i      (ex_history_i),
        .ex_target_i       (ex_target_i),
        .ex_inst_i         (ex_inst_i),
        .res               (res_bus.source)
    );

    btb u_btb (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc_i (if_pc_i),
        .res         (res_bus.sink),
        .hit_o       (btb_hit),
        .target_o    (btb_target)
    );

    direction_predictor u_direction_predictor (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc_i (if_pc_i),
        .res         (res_bus.sink),
        .taken_o     (dir_taken),
        .history_o   (history_o)
    );

    return_stack u_return_stack (
        .clk         (clk),
        .rst         (rst),
        .res         (res_bus.sink),
        .top_valid_o (ras_valid),
        .top_addr_o  (ras_addr)
    );

    next_pc_select u_next_pc_select (
        .flush_i         (flush_i),
        .if_pc_i         (if_pc_i),
        .kind_i          (if_kind),
        .branch_offset_i (if_branch_offset),
        .jal_offset_i    (if_jal_offset),
        .btb_hit_i       (btb_hit),
        .btb_target_i    (btb_target),
        .dir_taken_i     (dir_taken),
        .ras_valid_i     (ras_valid),
        .ras_addr_i      (ras_addr),
        .branch_or_not_o (branch_or_not_o),
        .pdt_pc_o        (pdt_pc_o),
        .pdt_res_o       (pdt_res_o)
    );

endmodule

// File: verification/bpu_tb.sv
`timescale 1ns/1ps

module bpu_tb
    import bpu_pkg::*;
();

    // limit is twice the summed test lengths
    localparam int test_count      = 6;
    localparam int cycles_per_test = 160;
    localparam int max_cycles      = 2 * test_count * cycles_per_test;

    logic                  clk;
    logic                  rst;
    logic                  if_stall_i;
    logic                  flush_i;
    logic [xlen-1:0]       if_pc_i;
    logic [xlen-1:0]       if_inst_i;
    logic                  ex_branch_valid_i;
    logic                  ex_branch_taken_i;
    logic [xlen-1:0]       ex_pc_i;
    logic [hist_width-1:0] ex_history_i;
    logic [xlen-1:0]       ex_target_i;
    logic [xlen-1:0]       ex_inst_i;
    logic                  branch_or_not_o;
    logic [xlen-1:0]       pdt_pc_o;
    logic                  pdt_res_o;
    logic [hist_width-1:0] history_o;

    // expected values for the lookup in flight
    logic                  chk_en;
    logic                  exp_bon;
    logic                  exp_res;
    logic [xlen-1:0]       exp_pc;
    logic [hist_width-1:0] exp_hist;

    // reference model
    logic [hist_width-1:0]    hist_m;
    ctr_t                     pht_m [pht_entries];
    logic                     btb_v_m [btb_entries];
    logic [btb_tag_width-1:0] btb_tag_m [btb_entries];
    logic [xlen-1:0]          btb_tgt_m [btb_entries];
    logic [xlen-1:0]          ras_m [$];

    string           cur_test;
    int              errors;
    int              errors_before;
    int              tests_run;
    int              tests_failed;
    int              cycle_count;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] lpc;
    logic [xlen-1:0] off;

    bpu_top u_bpu_top (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: no result after %0d cycles", max_cycles);
            $display("Regression failed");
            $finish;
        end
    end

    a_branch_or_not : assert property (@(posedge clk) chk_en |-> branch_or_not_o == exp_bon)
        else report_mismatch("branch_or_not_o", $sampled(exp_bon), $sampled(branch_or_not_o));
    a_pdt_res : assert property (@(posedge clk) chk_en |-> pdt_res_o == exp_res)
        else report_mismatch("pdt_res_o", $sampled(exp_res), $sampled(pdt_res_o));
    a_pdt_pc : assert property (@(posedge clk) chk_en |-> pdt_pc_o == exp_pc)
        else report_mismatch("pdt_pc_o", $sampled(exp_pc), $sampled(pdt_pc_o));
    a_history : assert property (@(posedge clk) chk_en |-> history_o == exp_hist)
        else report_mismatch("history_o", $sampled(exp_hist), $sampled(history_o));

    function automatic void report_mismatch(string sig, logic [xlen-1:0] exp_v,
                                            logic [xlen-1:0] act_v);
        errors++;
        $display("error %s: %s expected 0x%0h actual 0x%0h", cur_test, sig, exp_v, act_v);
    endfunction

    function automatic logic [xlen-1:0] encode_inst(branch_kind_t kind, logic [xlen-1:0] imm);
        case (kind)
            kind_branch:     return {imm[12], imm[10:5], 13'd0, imm[4:1], imm[11], op_branch};
            kind_jal:        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, op_jal};
            kind_call_jal:   return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, op_jal};
            kind_jalr_plain: return {12'd0, 5'd5, 3'd0, 5'd0, op_jalr};
            kind_call_jalr:  return {12'd0, 5'd5, 3'd0, 5'd1, op_jalr};
            kind_ret:        return {12'd0, 5'd1, 3'd0, 5'd0, op_jalr};
            // addi x0, x0, 0
            default:         return 32'h0000_0013;
        endcase
    endfunction

    function automatic logic [xlen-1:0] random_pc();
        logic [xlen-1:0] r;
        r = $urandom;
        return {r[xlen-1:2], 2'b00};
    endfunction

    // sign-extended b-type or j-type offset
    function automatic logic [xlen-1:0] offset_for(branch_kind_t kind);
        logic [xlen-1:0] r;
        r = $urandom;
        if (kind == kind_branch) begin
            return {{19{r[12]}}, r[12:1], 1'b0};
        end
        return {{11{r[20]}}, r[20:1], 1'b0};
    endfunction

    function automatic void expect_prediction(logic [xlen-1:0] at_pc, branch_kind_t kind,
                                              logic [xlen-1:0] imm);
        logic [btb_index_width-1:0] bi;
        logic [pht_index_width-1:0] pi;
        logic                       hit;
        bi       = at_pc[9:2];
        pi       = at_pc[9:1] ^ hist_m[8:0];
        hit      = btb_v_m[bi] && (btb_tag_m[bi] == at_pc[31:18]);
        exp_bon  = (kind != kind_none);
        exp_res  = 1'b0;
        exp_pc   = at_pc + 32'd4;
        exp_hist = hist_m;
        if (kind == kind_ret && ras_m.size() > 0) begin
            exp_res = 1'b1;
            exp_pc  = ras_m[$];
        end else if (kind inside {kind_ret, kind_jalr_plain, kind_call_jalr} && hit) begin
            exp_res = 1'b1;
            exp_pc  = btb_tgt_m[bi];
        end else if (kind inside {kind_jal, kind_call_jal}) begin
            exp_res = 1'b1;
            exp_pc  = at_pc + imm;
        end else if (kind == kind_branch && pht_m[pi][1]) begin
            exp_res = 1'b1;
            exp_pc  = hit ? btb_tgt_m[bi] : at_pc + imm;
        end
    endfunction

    function automatic void update_model(branch_kind_t kind, logic [xlen-1:0] rpc,
                                         logic taken, logic [xlen-1:0] tgt,
                                         logic [hist_width-1:0] h);
        logic [pht_index_width-1:0] pi;
        logic [btb_index_width-1:0] bi;
        pi = rpc[9:1] ^ h[8:0];
        bi = rpc[9:2];
        if (kind == kind_branch) begin
            if (taken && pht_m[pi] != 2'b11) begin
                pht_m[pi] = pht_m[pi] + 2'd1;
            end else if (!taken && pht_m[pi] != 2'b00) begin
                pht_m[pi] = pht_m[pi] - 2'd1;
            end
            hist_m = {hist_m[hist_width-2:0], taken};
        end
        if (taken && kind != kind_none) begin
            btb_v_m[bi]   = 1'b1;
            btb_tag_m[bi] = rpc[31:18];
            btb_tgt_m[bi] = tgt;
        end
        if (kind inside {kind_call_jal, kind_call_jalr}) begin
            // a push on a full stack keeps only the new entry
            if (ras_m.size() == ras_depth) begin
                ras_m.delete();
            end
            ras_m.push_back(rpc + 32'd4);
        end else if (kind == kind_ret && ras_m.size() > 0) begin
            void'(ras_m.pop_back());
        end
    endfunction

    task automatic lookup(branch_kind_t kind, logic [xlen-1:0] at_pc, logic [xlen-1:0] imm);
        if_pc_i           = at_pc;
        if_inst_i         = encode_inst(kind, imm);
        if_stall_i        = 1'b0;
        flush_i           = 1'b0;
        ex_branch_valid_i = 1'b0;
        expect_prediction(at_pc, kind, imm);
        chk_en = 1'b1;
        @(negedge clk);
    endtask

    task automatic commit(branch_kind_t kind, logic [xlen-1:0] rpc, logic taken,
                          logic [xlen-1:0] tgt, logic [hist_width-1:0] h, logic stall);
        ex_inst_i         = encode_inst(kind, offset_for(kind));
        ex_pc_i           = rpc;
        ex_branch_taken_i = taken;
        ex_target_i       = tgt;
        ex_history_i      = h;
        ex_branch_valid_i = 1'b1;
        if_stall_i        = stall;
        flush_i           = 1'b0;
        chk_en            = 1'b0;
        @(negedge clk);
        if (!stall) begin
            update_model(kind, rpc, taken, tgt, h);
        end
    endtask

    // a taken branch sits on the resolve bus and must be dropped
    task automatic flush_and_restore(branch_kind_t kind, logic [xlen-1:0] at_pc,
                                     logic [hist_width-1:0] h);
        if_pc_i           = at_pc;
        if_inst_i         = encode_inst(kind, offset_for(kind));
        ex_inst_i         = encode_inst(kind_branch, offset_for(kind_branch));
        ex_pc_i           = at_pc;
        ex_branch_taken_i = 1'b1;
        ex_target_i       = random_pc();
        ex_history_i      = h;
        ex_branch_valid_i = 1'b1;
        if_stall_i        = 1'b0;
        flush_i           = 1'b1;
        exp_bon           = 1'b0;
        exp_res           = 1'b0;
        exp_pc            = at_pc + 32'd4;
        exp_hist          = hist_m;
        chk_en            = 1'b1;
        @(negedge clk);
        hist_m = h;
    endtask

    task automatic begin_test(string name);
        cur_test      = name;
        errors_before = errors;
    endtask

    task automatic close_test();
        chk_en            = 1'b0;
        ex_branch_valid_i = 1'b0;
        flush_i           = 1'b0;
        if_stall_i        = 1'b0;
        @(negedge clk);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, errors - errors_before);
        end else begin
            $display("test %s: ok", cur_test);
        end
    endtask

    initial begin
        clk               = 1'b0;
        rst               = 1'b1;
        if_stall_i        = 1'b0;
        flush_i           = 1'b0;
        if_pc_i           = '0;
        if_inst_i         = '0;
        ex_branch_valid_i = 1'b0;
        ex_branch_taken_i = 1'b0;
        ex_pc_i           = '0;
        ex_history_i      = '0;
        ex_target_i       = '0;
        ex_inst_i         = '0;
        chk_en            = 1'b0;
        errors            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        cycle_count       = 0;
        void'($urandom(32'hbc5a));
        hist_m            = '0;
        for (int i = 0; i < pht_entries; i++) begin
            pht_m[i] = ctr_weak_nt;
        end
        for (int i = 0; i < btb_entries; i++) begin
            btb_v_m[i] = 1'b0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;

        begin_test("reset_jal");
        lookup(kind_jal, random_pc(), offset_for(kind_jal));
        lookup(kind_call_jal, random_pc(), offset_for(kind_call_jal));
        lookup(kind_branch, random_pc(), offset_for(kind_branch));
        lookup(kind_jalr_plain, random_pc(), '0);
        lookup(kind_none, random_pc(), '0);
        close_test();

        begin_test("direction");
        flush_and_restore(kind_none, random_pc(), 16'h00a5);
        pc  = random_pc();
        off = offset_for(kind_branch);
        commit(kind_branch, pc, 1'b1, pc + off, 16'h00a5, 1'b0);
        commit(kind_branch, pc, 1'b1, pc + off, 16'h00a5, 1'b0);
        // pick a pc that hashes onto the trained counter under the live history
        lpc = {pc[31:10], pc[9:1] ^ 9'h0a5 ^ hist_m[8:0], 1'b0};
        lookup(kind_branch, lpc, off);
        lookup(kind_branch, pc, off);
        close_test();

        begin_test("btb");
        pc = random_pc();
        commit(kind_jalr_plain, pc, 1'b1, random_pc(), hist_m, 1'b0);
        lookup(kind_jalr_plain, pc, '0);
        lookup(kind_call_jalr, pc, '0);
        lookup(kind_jalr_plain, pc ^ 32'h8000_0000, '0);
        close_test();

        begin_test("return_stack");
        for (int i = 0; i < 4; i++) begin
            commit((i % 2) ? kind_call_jalr : kind_call_jal, random_pc(), 1'b1,
                   random_pc(), hist_m, 1'b0);
        end
        for (int i = 0; i < 5; i++) begin
            pc = random_pc();
            lookup(kind_ret, pc, '0);
            commit(kind_ret, pc, 1'b1, exp_pc, hist_m, 1'b0);
        end
        lookup(kind_ret, random_pc(), '0);
        close_test();

        begin_test("flush");
        pc = random_pc();
        flush_and_restore(kind_branch, pc, 16'h3c1e);
        lookup(kind_branch, pc, offset_for(kind_branch));
        flush_and_restore(kind_jal, pc, hist_m ^ 16'h0101);
        lookup(kind_branch, pc, offset_for(kind_branch));
        close_test();

        begin_test("stall");
        pc = random_pc();
        commit(kind_branch, pc, 1'b1, random_pc(), hist_m, 1'b1);
        commit(kind_call_jal, pc, 1'b1, random_pc(), hist_m, 1'b1);
        commit(kind_jalr_plain, pc, 1'b1, random_pc(), hist_m, 1'b1);
        lookup(kind_jalr_plain, pc, '0);
        lookup(kind_ret, random_pc(), '0);
        lookup(kind_branch, pc, offset_for(kind_branch));
        close_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: flist.f
logic/bpu_pkg.sv
logic/resolve_if.sv
logic/inst_decode.sv
logic/resolve_stage.sv
logic/btb.sv
logic/direction_predictor.sv
logic/return_stack.sv
logic/next_pc_select.sv
logic/bpu_top.sv
verification/bpu_tb.sv

// File: Bender.yml
package:
  name: bpu

sources:
  - files:
      - logic/bpu_pkg.sv
      - logic/resolve_if.sv
      - logic/inst_decode.sv
      - logic/resolve_stage.sv
      - logic/btb.sv
      - logic/direction_predictor.sv
      - logic/return_stack.sv
      - logic/next_pc_select.sv
      - logic/bpu_top.sv
  - target: test
    files:
      - verification/bpu_tb.sv
